/* Makefile */
# Verilator build for the instruction-driven timer

VERILATOR ?= verilator
TOP ?= gbTimerTb
FILELIST ?= gbTimer.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* dv/gbTimerChecker.sv */
`timescale 1ns/1ns
`default_nettype none

module gbTimerChecker
(
    input wire iClock,
    input wire arstN,
    input wire eof,
    input wire [2:0] expCycles,
    input wire regWrite,
    input wire [timerPkg::regSelectWidth-1:0] regSelect,
    input wire [timerPkg::byteWidth-1:0] writeData,
    input wire checkNow,
    input wire [timerPkg::byteWidth-1:0] div,
    input wire [timerPkg::byteWidth-1:0] tima,
    input wire [timerPkg::byteWidth-1:0] tma,
    input wire [timerPkg::byteWidth-1:0] tac,
    input wire irq,
    output int valueErrors,
    output int irqErrors
);

    int sysModel;
    int timaModel;
    int tmaModel;
    int tacModel;
    int irqExpected;
    int irqSeen = 0;
    int valueCount = 0;
    int irqCount = 0;

    assign valueErrors = valueCount;
    assign irqErrors = irqCount;

    // Period in T-cycles for TAC bits 1:0
    function automatic int periodOf(input logic [1:0] code);
        case (timerPkg::tacSpeedE'(code))
            timerPkg::speed16: return 16;
            timerPkg::speed64: return 64;
            timerPkg::speed256: return 256;
            default: return 1024;
        endcase
    endfunction

    // One instruction of the model, floor rule over the system counter
    task applyStep(input int cycles);
        int oldCount;
        int newCount;
        int ticks;
        oldCount = sysModel;
        newCount = oldCount + cycles * 4;
        ticks = 0;
        if (tacModel[2])
        begin
            ticks = newCount / periodOf(tacModel[1:0]) - oldCount / periodOf(tacModel[1:0]);
        end
        sysModel = newCount % 65536;
        timaModel = timaModel + ticks;
        if (timaModel > 255)
        begin
            timaModel = (tmaModel + timaModel - 256) % 256;
            irqExpected = irqExpected + 1;
        end
    endtask

    task compareByte(input string name, input logic [7:0] got, input logic [7:0] expected);
        if (got !== expected)
        begin
            valueCount = valueCount + 1;
            $display("FAILED at %0t ns: %s got 0x%02h, expected 0x%02h",
                $time, name, got, expected);
        end
    endtask

    // ------------------------------
    // Model state, inputs are stable at the rising edge
    always @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            sysModel = 0;
            timaModel = 0;
            tmaModel = 0;
            tacModel = 0;
            irqExpected = 0;
        end
        else
        begin
            if (eof)
            begin
                applyStep(int'(expCycles));
            end
            if (regWrite)
            begin
                case (regSelect)
                    timerPkg::regDiv: sysModel = 0;
                    timerPkg::regTima: timaModel = int'(writeData);
                    timerPkg::regTma: tmaModel = int'(writeData);
                    default: tacModel = int'(writeData);
                endcase
            end
        end
    end

    // ------------------------------
    // DUT outputs are read at the falling edge
    always @(negedge iClock)
    begin
        if (arstN && irq)
        begin
            irqSeen = irqSeen + 1;
        end
        if (checkNow)
        begin
            compareByte("div", div, sysModel[15:8]);
            compareByte("tima", tima, timaModel[7:0]);
            compareByte("tma", tma, tmaModel[7:0]);
            compareByte("tac", tac, tacModel[7:0]);
            if (irqSeen != irqExpected)
            begin
                irqCount = irqCount + 1;
                $display("FAILED at %0t ns: irq pulse count got %0d, expected %0d",
                    $time, irqSeen, irqExpected);
                // Resync so one miss is reported once
                irqSeen = irqExpected;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/gbTimerTb.sv */
`timescale 1ns/1ns
`default_nettype none

module gbTimerTb;

    localparam int clockPeriod = 4;
    localparam int resetCycles = 5;
    localparam int idleCycles = 4;
    localparam int nRows = 33;
    localparam logic instrRow = 1'b0;
    localparam logic writeRow = 1'b1;

    typedef struct packed {
        logic kind;
        logic [7:0] opcode;
        logic cb;
        logic taken;
        logic [1:0] sel;
        logic [7:0] data;
        logic [3:0] randBits;
        logic [2:0] cycles;
        logic [7:0] repeats;
    } stimRowT;

    // kind, opcode, cb, taken, select, data, random bits, cycles, repeats
    // TIMA runs at the 16 T-cycle rate through the cycle rows, four strobes each
    localparam stimRowT stimTable [nRows] = '{
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h05, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'h00, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd1, 8'd4},
        '{instrRow, 8'h01, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd3, 8'd4},
        '{instrRow, 8'h08, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd5, 8'd4},
        '{instrRow, 8'h20, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd2, 8'd4},
        '{instrRow, 8'h20, 1'b0, 1'b1, timerPkg::regDiv, 8'h00, 4'd0, 3'd3, 8'd4},
        '{instrRow, 8'hC0, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd2, 8'd4},
        '{instrRow, 8'hC0, 1'b0, 1'b1, timerPkg::regDiv, 8'h00, 4'd0, 3'd5, 8'd4},
        '{instrRow, 8'hC4, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd3, 8'd4},
        '{instrRow, 8'hC4, 1'b0, 1'b1, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd4},
        '{instrRow, 8'hCD, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd4},
        '{instrRow, 8'h06, 1'b1, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd4, 8'd4},
        '{instrRow, 8'h46, 1'b1, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd3, 8'd4},
        '{instrRow, 8'h11, 1'b1, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd2, 8'd4},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd8, 3'd0, 8'd1},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h05, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'hCD, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd5},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h06, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'h08, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd5, 8'd8},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h07, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'hCD, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd10},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h04, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'hCD, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd12},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h01, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'hCD, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd6},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTma, 8'h00, 4'd7, 3'd0, 8'd1},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'h05, 4'd0, 3'd0, 8'd1},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTima, 8'hFD, 4'd0, 3'd0, 8'd1},
        '{instrRow, 8'hCD, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd6, 8'd3},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd8, 3'd0, 8'd1},
        '{instrRow, 8'h00, 1'b0, 1'b0, timerPkg::regDiv, 8'h00, 4'd0, 3'd1, 8'd1},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTma, 8'h3C, 4'd0, 3'd0, 8'd1},
        '{writeRow, 8'h00, 1'b0, 1'b0, timerPkg::regTac, 8'hFA, 4'd0, 3'd0, 8'd1}
    };

    logic iClock;
    logic arstN;
    logic eof;
    logic [7:0] opcode;
    logic cbPrefixed;
    logic branchTaken;
    logic regWrite;
    logic [1:0] regSelect;
    logic [7:0] writeData;
    logic [2:0] expCycles;
    logic checkNow;
    logic [7:0] div;
    logic [7:0] tima;
    logic [7:0] tma;
    logic [7:0] tac;
    logic irq;
    int valueErrors;
    int irqErrors;
    logic [31:0] lfsrState;

    gbTimer dut0 (
        .iClock(iClock),
        .arstN(arstN),
        .eof(eof),
        .opcode(opcode),
        .cbPrefixed(cbPrefixed),
        .branchTaken(branchTaken),
        .regWrite(regWrite),
        .regSelect(regSelect),
        .writeData(writeData),
        .div(div),
        .tima(tima),
        .tma(tma),
        .tac(tac),
        .irq(irq)
    );

    gbTimerChecker checker0 (
        .iClock(iClock),
        .arstN(arstN),
        .eof(eof),
        .expCycles(expCycles),
        .regWrite(regWrite),
        .regSelect(regSelect),
        .writeData(writeData),
        .checkNow(checkNow),
        .div(div),
        .tima(tima),
        .tma(tma),
        .tac(tac),
        .irq(irq),
        .valueErrors(valueErrors),
        .irqErrors(irqErrors)
    );

    // Right-shifting Galois LFSR
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 32'hD000_0001;
        end
        return next;
    endfunction

    task automatic takeRandom(input int nBits, output logic [7:0] value);
        value = '0;
        for (int b = 0; b < nBits; b++)
        begin
            value = {value[6:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic driveIdle();
        eof = 1'b0;
        opcode = '0;
        cbPrefixed = 1'b0;
        branchTaken = 1'b0;
        regWrite = 1'b0;
        regSelect = '0;
        writeData = '0;
        expCycles = '0;
    endtask

    // ------------------------------
    // One table row, idle gap, then a check cycle
    task automatic applyRow(input stimRowT row);
        logic [7:0] value;
        value = row.data;
        if (row.kind == writeRow && row.randBits != 4'd0)
        begin
            takeRandom(int'(row.randBits), value);
        end
        for (int n = 0; n < int'(row.repeats); n++)
        begin
            @(posedge iClock);
            #1;
            if (row.kind == writeRow)
            begin
                regWrite = 1'b1;
                regSelect = row.sel;
                writeData = value;
            end
            else
            begin
                eof = 1'b1;
                opcode = row.opcode;
                cbPrefixed = row.cb;
                branchTaken = row.taken;
                expCycles = row.cycles;
            end
        end
        repeat (idleCycles)
        begin
            @(posedge iClock);
            #1;
            driveIdle();
        end
        @(posedge iClock);
        #1;
        checkNow = 1'b1;
        @(posedge iClock);
        #1;
        checkNow = 1'b0;
    endtask

    initial
    begin
        iClock = 1'b0;
        forever
        begin
            #(clockPeriod / 2) iClock = ~iClock;
        end
    end

    initial
    begin
        arstN = 1'b1;
        checkNow = 1'b0;
        driveIdle();
        lfsrState = 32'h18f3_c9ad;
        #1 arstN = 1'b0;
        repeat (resetCycles) @(posedge iClock);
        #1 arstN = 1'b1;
        for (int i = 0; i < nRows; i++)
        begin
            applyRow(stimTable[i]);
        end
        $display("Error counts: %0d value, %0d irq, %0d assertion",
            valueErrors, irqErrors, dut0.assert0.assertErrors);
        if (valueErrors == 0 && irqErrors == 0 && dut0.assert0.assertErrors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

    // ------------------------------
    // Watchdog sized from the table
    initial
    begin
        int totalRepeats;
        int limitNs;
        totalRepeats = 0;
        for (int i = 0; i < nRows; i++)
        begin
            totalRepeats = totalRepeats + int'(stimTable[i].repeats);
        end
        limitNs = (totalRepeats + 6 * nRows) * clockPeriod * 2;
        #(limitNs);
        $display("Watchdog expired after %0d ns, the stimulus did not complete", limitNs);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/gbTimer_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module gbTimerAssert
(
    input wire iClock,
    input wire arstN,
    input wire regWrite,
    input wire [timerPkg::regSelectWidth-1:0] regSelect,
    input wire [timerPkg::byteWidth-1:0] div,
    input wire [timerPkg::byteWidth-1:0] tima,
    input wire [timerPkg::byteWidth-1:0] tma,
    input wire [timerPkg::byteWidth-1:0] tac,
    input wire irq
);

    // Number of failed assertions
    int assertErrors = 0;

    // Interrupt is a single-cycle pulse
    irqSinglePulse: assert property (@(posedge iClock) disable iff (!arstN)
        irq |=> !irq)
        else
        begin
            $error("irq stayed high for more than one cycle");
            assertErrors = assertErrors + 1;
        end

    // A DIV write clears the divider on the next edge
    divWriteClears: assert property (@(posedge iClock) disable iff (!arstN)
        (regWrite && regSelect == timerPkg::regDiv) |=> (div == '0))
        else
        begin
            $error("div not zero one cycle after a DIV write");
            assertErrors = assertErrors + 1;
        end

    // Everything visible is cleared while reset is held
    resetOutputsZero: assert property (@(posedge iClock)
        !arstN |-> (div == '0 && tima == '0 && tma == '0 && tac == '0 && !irq))
        else
        begin
            $error("outputs not zero during reset");
            assertErrors = assertErrors + 1;
        end

endmodule

bind gbTimer gbTimerAssert assert0 (
    .iClock(iClock),
    .arstN(arstN),
    .regWrite(regWrite),
    .regSelect(regSelect),
    .div(div),
    .tima(tima),
    .tma(tma),
    .tac(tac),
    .irq(irq)
);

`default_nettype wire

/* gbTimer.f */
verilog/timerPkg.sv
verilog/timerCtrlIf.sv
verilog/cpuRegPort.sv
verilog/cycleDecoder.sv
verilog/cycleCounter.sv
verilog/timaCounter.sv
verilog/gbTimer.sv
dv/gbTimer_assert.sv
dv/gbTimerChecker.sv
dv/gbTimerTb.sv

/* verilog/cpuRegPort.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuRegPort
(
    input wire iClock,
    input wire arstN,
    input wire regWrite,
    input wire [timerPkg::regSelectWidth-1:0] regSelect,
    input wire [timerPkg::byteWidth-1:0] writeData,
    output logic [timerPkg::byteWidth-1:0] tac,
    output logic [timerPkg::byteWidth-1:0] tma,
    timerCtrlIf.driver ctrl
);

    logic tacWrite;
    logic tmaWrite;

    // ------------------------------
    // Write decode
    assign tacWrite = regWrite && (regSelect == timerPkg::regTac);
    assign tmaWrite = regWrite && (regSelect == timerPkg::regTma);

    // DIV and TIMA writes act on the counters directly
    // so the new value shows one edge after the write
    assign ctrl.divClear = regWrite && (regSelect == timerPkg::regDiv);
    assign ctrl.timaLoad = regWrite && (regSelect == timerPkg::regTima);
    assign ctrl.timaLoadData = writeData;

    // ------------------------------
    // TAC and TMA storage
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            tac <= '0;
            tma <= '0;
        end
        else
        begin
            if (tacWrite)
            begin
                tac <= writeData;
            end
            if (tmaWrite)
            begin
                tma <= writeData;
            end
        end
    end

    // Bits 1:0 pick the period, bit 2 runs the timer
    assign ctrl.speed = timerPkg::tacSpeedE'(tac[1:0]);
    assign ctrl.timerEnable = tac[2];
    assign ctrl.modulo = tma;

endmodule

`default_nettype wire

/* verilog/cycleCounter.sv */
`timescale 1ns/1ns
`default_nettype none

module cycleCounter
(
    input wire iClock,
    input wire arstN,
    input wire stepValid,
    input wire [timerPkg::mCycleWidth-1:0] stepCycles,
    timerCtrlIf.sysRx ctrl,
    output logic [timerPkg::byteWidth-1:0] div,
    output logic [1:0] tickCount
);

    logic [timerPkg::sysCountWidth-1:0] sysCount;
    logic [timerPkg::sysCountWidth:0] stepTicks;
    logic [timerPkg::sysCountWidth:0] sumWide;
    logic [timerPkg::sysCountWidth:0] crossed;
    logic [3:0] periodShift;

    // T-cycles added by this step, carry bit kept for the crossing count
    assign stepTicks = stepCycles * timerPkg::tCyclesPerMCycle;
    assign sumWide = {1'b0, sysCount} + stepTicks;

    // log2 of the selected period
    always_comb
    begin
        case (ctrl.speed)
            timerPkg::speed16: periodShift = 4'd4;
            timerPkg::speed64: periodShift = 4'd6;
            timerPkg::speed256: periodShift = 4'd8;
            default: periodShift = 4'd10;
        endcase
    end

    // Period multiples passed between old and new count
    assign crossed = (sumWide >> periodShift) - ({1'b0, sysCount} >> periodShift);

    // ------------------------------
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            sysCount <= '0;
            tickCount <= 2'd0;
        end
        else if (ctrl.divClear)
        begin
            // Clear beats a step in the same cycle
            sysCount <= '0;
            tickCount <= 2'd0;
        end
        else
        begin
            if (stepValid)
            begin
                sysCount <= sumWide[timerPkg::sysCountWidth-1:0];
            end
            tickCount <= (stepValid && ctrl.timerEnable) ? crossed[1:0] : 2'd0;
        end
    end

    assign div = sysCount[timerPkg::sysCountWidth-1 -: timerPkg::byteWidth];

endmodule

`default_nettype wire

/* verilog/cycleDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module cycleDecoder
(
    input wire iClock,
    input wire arstN,
    input wire eof,
    input wire [timerPkg::byteWidth-1:0] opcode,
    input wire cbPrefixed,
    input wire branchTaken,
    output logic stepValid,
    output logic [timerPkg::mCycleWidth-1:0] stepCycles
);

    logic [timerPkg::mCycleWidth-1:0] lookupCycles;

    // ------------------------------
    // Machine cycle lookup
    always_comb
    begin
        if (cbPrefixed)
        begin
            // Register code 6 is the (HL) operand
            if (opcode[2:0] == 3'd6)
            begin
                // BIT only reads memory, one cycle shorter
                if (opcode[7:6] == 2'b01)
                begin
                    lookupCycles = 3'd3;
                end
                else
                begin
                    lookupCycles = 3'd4;
                end
            end
            else
            begin
                lookupCycles = 3'd2;
            end
        end
        else if (branchTaken)
        begin
            lookupCycles = timerPkg::branchCycles[opcode];
        end
        else
        begin
            lookupCycles = timerPkg::baseCycles[opcode];
        end
    end

    // ------------------------------
    // Step strobe, one cycle behind eof
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            stepValid <= 1'b0;
            stepCycles <= '0;
        end
        else
        begin
            stepValid <= eof;
            // Cycle count travels with the strobe
            if (eof)
            begin
                stepCycles <= lookupCycles;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/gbTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module gbTimer
(
    input wire iClock,
    input wire arstN,

    // End-of-instruction strobe from the CPU
    input wire eof,
    input wire [timerPkg::byteWidth-1:0] opcode,
    input wire cbPrefixed,
    input wire branchTaken,

    // CPU register writes
    input wire regWrite,
    input wire [timerPkg::regSelectWidth-1:0] regSelect,
    input wire [timerPkg::byteWidth-1:0] writeData,

    output logic [timerPkg::byteWidth-1:0] div,
    output logic [timerPkg::byteWidth-1:0] tima,
    output logic [timerPkg::byteWidth-1:0] tma,
    output logic [timerPkg::byteWidth-1:0] tac,
    output logic irq
);

    logic stepValid;
    logic [timerPkg::mCycleWidth-1:0] stepCycles;
    logic [1:0] tickCount;

    timerCtrlIf ctrlBus ();

    // ------------------------------
    // Input side
    cpuRegPort regPort0 (
        .iClock(iClock),
        .arstN(arstN),
        .regWrite(regWrite),
        .regSelect(regSelect),
        .writeData(writeData),
        .tac(tac),
        .tma(tma),
        .ctrl(ctrlBus.driver)
    );

    cycleDecoder decoder0 (
        .iClock(iClock),
        .arstN(arstN),
        .eof(eof),
        .opcode(opcode),
        .cbPrefixed(cbPrefixed),
        .branchTaken(branchTaken),
        .stepValid(stepValid),
        .stepCycles(stepCycles)
    );

    // ------------------------------
    // System counter, then TIMA
    cycleCounter counter0 (
        .iClock(iClock),
        .arstN(arstN),
        .stepValid(stepValid),
        .stepCycles(stepCycles),
        .ctrl(ctrlBus.sysRx),
        .div(div),
        .tickCount(tickCount)
    );

    timaCounter tima0 (
        .iClock(iClock),
        .arstN(arstN),
        .tickCount(tickCount),
        .ctrl(ctrlBus.timaRx),
        .tima(tima),
        .irq(irq)
    );

endmodule

`default_nettype wire

/* verilog/timaCounter.sv */
`timescale 1ns/1ns
`default_nettype none

module timaCounter
(
    input wire iClock,
    input wire arstN,
    input wire [1:0] tickCount,
    timerCtrlIf.timaRx ctrl,
    output logic [timerPkg::byteWidth-1:0] tima,
    output logic irq
);

    logic [timerPkg::byteWidth:0] timaSum;
    logic overflow;

    // Bit 8 marks a pass beyond 255
    assign timaSum = {1'b0, tima} + tickCount;
    assign overflow = timaSum[timerPkg::byteWidth];

    // ------------------------------
    always_ff @(posedge iClock or negedge arstN)
    begin
        if (!arstN)
        begin
            tima <= '0;
            irq <= 1'b0;
        end
        else if (ctrl.timaLoad)
        begin
            // CPU load drops this cycle's ticks
            tima <= ctrl.timaLoadData;
            irq <= 1'b0;
        end
        else if (overflow)
        begin
            // Low byte of the sum is the excess minus one
            tima <= ctrl.modulo + timaSum[timerPkg::byteWidth-1:0];
            irq <= 1'b1;
        end
        else
        begin
            tima <= timaSum[timerPkg::byteWidth-1:0];
            irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/timerCtrlIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface timerCtrlIf;

    // Levels decoded from TAC and TMA
    logic timerEnable;
    timerPkg::tacSpeedE speed;
    logic [timerPkg::byteWidth-1:0] modulo;

    // Single-cycle pulses from CPU writes
    logic divClear;
    logic timaLoad;
    logic [timerPkg::byteWidth-1:0] timaLoadData;

    modport driver (
        output timerEnable, speed, modulo, divClear, timaLoad, timaLoadData
    );

    // System counter side
    modport sysRx (input timerEnable, speed, divClear);

    // TIMA side
    modport timaRx (input modulo, timaLoad, timaLoadData);

endinterface

`default_nettype wire

/* verilog/timerPkg.sv */
`default_nettype none

package timerPkg;

    // Datapath widths
    localparam int byteWidth = 8;
    localparam int sysCountWidth = 16;
    localparam int mCycleWidth = 3;
    localparam int regSelectWidth = 2;

    // CPU register select codes
    localparam logic [regSelectWidth-1:0] regDiv = 2'd0;
    localparam logic [regSelectWidth-1:0] regTima = 2'd1;
    localparam logic [regSelectWidth-1:0] regTma = 2'd2;
    localparam logic [regSelectWidth-1:0] regTac = 2'd3;

    // Sized to the system counter so the step product keeps its full width
    localparam logic [sysCountWidth-1:0] tCyclesPerMCycle = 4;

    // TAC bits 1:0, each named after its period in T-cycles
    typedef enum logic [1:0] {
        speed1024 = 2'd0,
        speed16 = 2'd1,
        speed64 = 2'd2,
        speed256 = 2'd3
    } tacSpeedE;

    // ------------------------------
    // Machine cycles per opcode, conditional branches not taken
    // One line per high nibble, low nibble left to right
    localparam logic [mCycleWidth-1:0] baseCycles [256] = '{
        1, 3, 2, 2, 1, 1, 2, 1, 5, 2, 2, 2, 1, 1, 2, 1,
        1, 3, 2, 2, 1, 1, 2, 1, 3, 2, 2, 2, 1, 1, 2, 1,
        2, 3, 2, 2, 1, 1, 2, 1, 2, 2, 2, 2, 1, 1, 2, 1,
        2, 3, 2, 2, 3, 3, 3, 1, 2, 2, 2, 2, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        2, 2, 2, 2, 2, 2, 1, 2, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        2, 3, 3, 4, 3, 4, 2, 4, 2, 4, 3, 0, 3, 6, 2, 4,
        2, 3, 3, 0, 3, 4, 2, 4, 2, 4, 3, 0, 3, 0, 2, 4,
        3, 3, 2, 0, 0, 4, 2, 4, 4, 1, 4, 0, 0, 0, 2, 4,
        3, 3, 2, 1, 0, 4, 2, 4, 3, 2, 4, 1, 0, 0, 2, 4
    };

    // ------------------------------
    // Same layout for a taken branch
    // Only JR cc, RET cc, JP cc and CALL cc differ from the base table
    localparam logic [mCycleWidth-1:0] branchCycles [256] = '{
        1, 3, 2, 2, 1, 1, 2, 1, 5, 2, 2, 2, 1, 1, 2, 1,
        1, 3, 2, 2, 1, 1, 2, 1, 3, 2, 2, 2, 1, 1, 2, 1,
        3, 3, 2, 2, 1, 1, 2, 1, 3, 2, 2, 2, 1, 1, 2, 1,
        3, 3, 2, 2, 3, 3, 3, 1, 3, 2, 2, 2, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        2, 2, 2, 2, 2, 2, 1, 2, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        1, 1, 1, 1, 1, 1, 2, 1, 1, 1, 1, 1, 1, 1, 2, 1,
        5, 3, 4, 4, 6, 4, 2, 4, 5, 4, 4, 0, 6, 6, 2, 4,
        5, 3, 4, 0, 6, 4, 2, 4, 5, 4, 4, 0, 6, 0, 2, 4,
        3, 3, 2, 0, 0, 4, 2, 4, 4, 1, 4, 0, 0, 0, 2, 4,
        3, 3, 2, 1, 0, 4, 2, 4, 3, 2, 4, 1, 0, 0, 2, 4
    };

endpackage

`default_nettype wire
